// ==== frontend_defines.svh ====
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~
// datapath

`define XLEN            32              // data and address width
`define RESET_PC        32'h0000_0000   // fetch pc out of reset

// ~~~~~~~~~~~~~~~~~~~~
// configuration word offsets, 2-bit word address

`define CFG_CTRL        2'd0            // bit 0 enable, bit 1 redirect
`define CFG_START_PC    2'd1
`define CFG_ISSUED      2'd2            // read only
// offset 3 is unmapped and reads zero

`endif

// ==== frontend_pkg.sv ====
package frontend_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // rv32i major opcodes

    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,   // fence
        OPC_SYSTEM   = 7'b1110011    // csr, ecall, ebreak
    } opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // immediate formats

    typedef enum logic [2:0] {
        IMM_I,      // 12 bit, bits 31:20
        IMM_S,      // split store offset
        IMM_B,      // branch offset, bit 0 zero
        IMM_U,      // upper 20 bits
        IMM_J,      // jump offset, bit 0 zero
        IMM_NONE    // register-register or illegal
    } imm_fmt_e;

endpackage

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_unit (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              enable,
    input  logic [`XLEN-1:0]  start_pc,
    input  logic              redirect,
    input  logic              stall,
    input  logic [`XLEN-1:0]  ibus_dat_r,
    input  logic              ibus_ack,
    output logic              ibus_cyc,
    output logic              ibus_stb,
    output logic [`XLEN-1:0]  ibus_adr,
    output logic              fet_valid,
    output logic [`XLEN-1:0]  fet_pc,
    output logic [`XLEN-1:0]  fet_instr
);

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_REQ,
        FS_DISCARD
    } fetch_state_e;

    fetch_state_e       state;
    logic [`XLEN-1:0]   pc;         // next address to fetch
    logic               out_free;
    logic               accept;

    // output register empty after this edge, stays empty until our ack
    assign out_free = !fet_valid || !stall;
    assign accept   = (state == FS_REQ) && ibus_ack && !redirect;

    assign ibus_cyc = (state != FS_IDLE);
    assign ibus_stb = ibus_cyc;

    // ~~~~~~~~~~~~~~~~~~~~
    // bus master fsm

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state     <= FS_IDLE;
            pc        <= `RESET_PC;
            fet_valid <= 1'b0;
        end else begin
            if (redirect) begin
                fet_valid <= 1'b0;
            end else if (accept) begin
                fet_valid <= 1'b1;
            end else if (!stall) begin
                fet_valid <= 1'b0;              // taken by decode
            end

            case (state)
                FS_IDLE: begin
                    if (redirect || !enable) begin
                        pc <= start_pc;         // idle core follows start pc
                    end else if (out_free) begin
                        state <= FS_REQ;
                    end
                end
                FS_REQ: begin
                    if (ibus_ack) begin
                        state <= FS_IDLE;
                        pc    <= redirect ? start_pc : ibus_adr + `XLEN'd4;
                    end else if (redirect) begin
                        state <= FS_DISCARD;    // finish cycle, drop word
                        pc    <= start_pc;
                    end
                end
                FS_DISCARD: begin
                    if (redirect) begin
                        pc <= start_pc;
                    end
                    if (ibus_ack) begin
                        state <= FS_IDLE;
                    end
                end
                default: begin
                    state <= FS_IDLE;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // address and captured word

    always_ff @(posedge CLK) begin
        if (state == FS_IDLE) begin
            ibus_adr <= pc;                     // frozen once cyc rises
        end
        if (accept) begin
            fet_pc    <= ibus_adr;
            fet_instr <= ibus_dat_r;
        end
    end

endmodule

// ==== decode_1st.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module decode_1st (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    stall,
    input  logic                    fet_valid,
    input  logic [`XLEN-1:0]        fet_pc,
    input  logic [`XLEN-1:0]        fet_instr,
    output logic                    d1_valid,
    output logic [`XLEN-1:0]        d1_pc,
    output frontend_pkg::opcode_e   d1_opcode,
    output logic [4:0]              d1_rd,
    output logic [4:0]              d1_rs1,
    output logic [4:0]              d1_rs2,
    output logic [2:0]              d1_funct3,
    output logic [6:0]              d1_funct7,
    output logic [`XLEN-1:0]        d1_imm,
    output logic                    d1_illegal
);

    import frontend_pkg::*;

    logic [6:0]         op_bits;
    imm_fmt_e           fmt;
    logic               known;
    logic [`XLEN-1:0]   imm;

    assign op_bits = fet_instr[6:0];

    // ~~~~~~~~~~~~~~~~~~~~
    // opcode to format

    always_comb begin
        known = 1'b1;
        case (op_bits)
            OPC_LUI, OPC_AUIPC:                         fmt = IMM_U;
            OPC_JAL:                                    fmt = IMM_J;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM:             fmt = IMM_I;
            OPC_MISC_MEM, OPC_SYSTEM:                   fmt = IMM_I;    // csr in 31:20
            OPC_BRANCH:                                 fmt = IMM_B;
            OPC_STORE:                                  fmt = IMM_S;
            OPC_OP:                                     fmt = IMM_NONE;
            default: begin
                fmt   = IMM_NONE;
                known = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (fmt)
            IMM_I:   imm = {{20{fet_instr[31]}}, fet_instr[31:20]};
            IMM_S:   imm = {{20{fet_instr[31]}}, fet_instr[31:25], fet_instr[11:7]};
            IMM_B:   imm = {{19{fet_instr[31]}}, fet_instr[31], fet_instr[7],
                            fet_instr[30:25], fet_instr[11:8], 1'b0};
            IMM_U:   imm = {fet_instr[31:12], 12'h000};
            IMM_J:   imm = {{11{fet_instr[31]}}, fet_instr[31], fet_instr[19:12],
                            fet_instr[20], fet_instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stage register

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            d1_valid   <= 1'b0;
            d1_pc      <= '0;
            d1_opcode  <= opcode_e'(7'h00);
            d1_rd      <= '0;
            d1_rs1     <= '0;
            d1_rs2     <= '0;
            d1_funct3  <= '0;
            d1_funct7  <= '0;
            d1_imm     <= '0;
            d1_illegal <= 1'b0;
        end else if (!stall) begin
            d1_valid   <= fet_valid;
            d1_pc      <= fet_pc;
            d1_opcode  <= opcode_e'(op_bits);   // raw bits kept when illegal
            d1_rd      <= fet_instr[11:7];
            d1_rs1     <= fet_instr[19:15];
            d1_rs2     <= fet_instr[24:20];
            d1_funct3  <= fet_instr[14:12];
            d1_funct7  <= fet_instr[31:25];
            d1_imm     <= imm;
            d1_illegal <= !known || (op_bits[1:0] != 2'b11);
        end
    end

endmodule

// ==== decode_2nd.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module decode_2nd (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    stall,
    input  logic                    d1_valid,
    input  logic [`XLEN-1:0]        d1_pc,
    input  frontend_pkg::opcode_e   d1_opcode,
    input  logic [4:0]              d1_rd,
    input  logic [4:0]              d1_rs1,
    input  logic [4:0]              d1_rs2,
    input  logic [2:0]              d1_funct3,
    input  logic [6:0]              d1_funct7,
    input  logic [`XLEN-1:0]        d1_imm,
    input  logic                    d1_illegal,
    output logic                    dec_valid,
    output logic [`XLEN-1:0]        dec_pc,
    output frontend_pkg::opcode_e   dec_opcode,
    output logic [4:0]              dec_rd,
    output logic [4:0]              dec_rs1,
    output logic [4:0]              dec_rs2,
    output logic [11:0]             dec_csr,
    output logic [2:0]              dec_funct3,
    output logic [6:0]              dec_funct7,
    output logic [`XLEN-1:0]        dec_imm,
    output logic                    dec_illegal
);

    import frontend_pkg::*;

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            dec_valid   <= 1'b0;
            dec_pc      <= '0;
            dec_opcode  <= opcode_e'(7'h00);
            dec_rd      <= '0;
            dec_rs1     <= '0;
            dec_rs2     <= '0;
            dec_funct3  <= '0;
            dec_funct7  <= '0;
            dec_imm     <= '0;
            dec_illegal <= 1'b0;
        end else if (!stall) begin
            dec_valid   <= d1_valid;
            dec_pc      <= d1_pc;
            dec_opcode  <= d1_opcode;
            dec_rd      <= d1_rd;
            dec_rs1     <= d1_rs1;
            dec_rs2     <= d1_rs2;
            dec_funct3  <= d1_funct3;
            dec_funct7  <= d1_funct7;
            dec_imm     <= d1_imm;
            dec_illegal <= d1_illegal;
        end
    end

    assign dec_csr = dec_imm[11:0];     // i-format field, bits 31:20 of word

endmodule

// ==== frontend_cfg.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module frontend_cfg (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              cfg_cyc,
    input  logic              cfg_stb,
    input  logic              cfg_we,
    input  logic [1:0]        cfg_adr,
    input  logic [`XLEN-1:0]  cfg_dat_w,
    input  logic              dec_valid,
    input  logic              stall,
    output logic [`XLEN-1:0]  cfg_dat_r,
    output logic              cfg_ack,
    output logic              enable,
    output logic [`XLEN-1:0]  start_pc,
    output logic              redirect
);

    logic               req;
    logic               wr_ctrl;
    logic               wr_start;
    logic [`XLEN-1:0]   issued;
    logic [`XLEN-1:0]   rd_word;

    // no new request seen in the ack cycle
    assign req      = cfg_cyc && cfg_stb && !cfg_ack;
    assign wr_ctrl  = req && cfg_we && (cfg_adr == `CFG_CTRL);
    assign wr_start = req && cfg_we && (cfg_adr == `CFG_START_PC);

    // ~~~~~~~~~~~~~~~~~~~~
    // registers

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            cfg_ack  <= 1'b0;
            enable   <= 1'b0;
            start_pc <= '0;
            redirect <= 1'b0;
            issued   <= '0;
        end else begin
            cfg_ack  <= req;
            redirect <= wr_ctrl && cfg_dat_w[1];    // one cycle pulse
            if (wr_ctrl) begin
                enable <= cfg_dat_w[0];
            end
            if (wr_start) begin
                start_pc <= cfg_dat_w;
            end
            if (dec_valid && !stall) begin
                issued <= issued + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read path

    always_comb begin
        case (cfg_adr)
            `CFG_CTRL:     rd_word = {{(`XLEN-1){1'b0}}, enable};  // redirect reads 0
            `CFG_START_PC: rd_word = start_pc;
            `CFG_ISSUED:   rd_word = issued;
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (req) begin
            cfg_dat_r <= rd_word;       // valid with ack
        end
    end

endmodule

// ==== decode_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module decode_frontend (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    stall,
    output logic                    ibus_cyc,
    output logic                    ibus_stb,
    output logic [`XLEN-1:0]        ibus_adr,
    input  logic [`XLEN-1:0]        ibus_dat_r,
    input  logic                    ibus_ack,
    input  logic                    cfg_cyc,
    input  logic                    cfg_stb,
    input  logic                    cfg_we,
    input  logic [1:0]              cfg_adr,
    input  logic [`XLEN-1:0]        cfg_dat_w,
    output logic [`XLEN-1:0]        cfg_dat_r,
    output logic                    cfg_ack,
    output logic                    dec_valid,
    output logic [`XLEN-1:0]        dec_pc,
    output frontend_pkg::opcode_e   dec_opcode,
    output logic [4:0]              dec_rd,
    output logic [4:0]              dec_rs1,
    output logic [4:0]              dec_rs2,
    output logic [11:0]             dec_csr,
    output logic [2:0]              dec_funct3,
    output logic [6:0]              dec_funct7,
    output logic [`XLEN-1:0]        dec_imm,
    output logic                    dec_illegal
);

    import frontend_pkg::*;

    // config to fetch
    logic               enable;
    logic [`XLEN-1:0]   start_pc;
    logic               redirect;       // also flushes decode

    // fetch to decode_1st
    logic               fet_valid;
    logic [`XLEN-1:0]   fet_pc;
    logic [`XLEN-1:0]   fet_instr;

    // ~~~~~~~~~~~~~~~~~~~~
    // decode_1st to decode_2nd

    logic               d1_valid;
    logic [`XLEN-1:0]   d1_pc;
    opcode_e            d1_opcode;
    logic [4:0]         d1_rd;
    logic [4:0]         d1_rs1;
    logic [4:0]         d1_rs2;
    logic [2:0]         d1_funct3;
    logic [6:0]         d1_funct7;
    logic [`XLEN-1:0]   d1_imm;
    logic               d1_illegal;

    frontend_cfg u_cfg (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .cfg_cyc   (cfg_cyc),
        .cfg_stb   (cfg_stb),
        .cfg_we    (cfg_we),
        .cfg_adr   (cfg_adr),
        .cfg_dat_w (cfg_dat_w),
        .dec_valid (dec_valid),
        .stall     (stall),
        .cfg_dat_r (cfg_dat_r),
        .cfg_ack   (cfg_ack),
        .enable    (enable),
        .start_pc  (start_pc),
        .redirect  (redirect)
    );

    fetch_unit u_fetch (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .enable     (enable),
        .start_pc   (start_pc),
        .redirect   (redirect),
        .stall      (stall),
        .ibus_dat_r (ibus_dat_r),
        .ibus_ack   (ibus_ack),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .fet_valid  (fet_valid),
        .fet_pc     (fet_pc),
        .fet_instr  (fet_instr)
    );

    decode_1st u_dec1 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .flush      (redirect),
        .stall      (stall),
        .fet_valid  (fet_valid),
        .fet_pc     (fet_pc),
        .fet_instr  (fet_instr),
        .d1_valid   (d1_valid),
        .d1_pc      (d1_pc),
        .d1_opcode  (d1_opcode),
        .d1_rd      (d1_rd),
        .d1_rs1     (d1_rs1),
        .d1_rs2     (d1_rs2),
        .d1_funct3  (d1_funct3),
        .d1_funct7  (d1_funct7),
        .d1_imm     (d1_imm),
        .d1_illegal (d1_illegal)
    );

    decode_2nd u_dec2 (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .flush       (redirect),
        .stall       (stall),
        .d1_valid    (d1_valid),
        .d1_pc       (d1_pc),
        .d1_opcode   (d1_opcode),
        .d1_rd       (d1_rd),
        .d1_rs1      (d1_rs1),
        .d1_rs2      (d1_rs2),
        .d1_funct3   (d1_funct3),
        .d1_funct7   (d1_funct7),
        .d1_imm      (d1_imm),
        .d1_illegal  (d1_illegal),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_opcode  (dec_opcode),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_csr     (dec_csr),
        .dec_funct3  (dec_funct3),
        .dec_funct7  (dec_funct7),
        .dec_imm     (dec_imm),
        .dec_illegal (dec_illegal)
    );

endmodule

// ==== tb_imem_model.sv ====
`timescale 1ns/1ps

module tb_imem_model #(
    parameter logic [31:0] SEED = 32'h94d1
) (
    input  logic        CLK,
    input  logic        cyc,
    input  logic        stb,
    input  logic [31:0] adr,
    output logic [31:0] dat_r,
    output logic        ack
);

    logic [31:0] mem [0:63];    // filled by the testbench
    logic [31:0] rnd;
    logic [1:0]  wait_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        ack       = 1'b0;
        dat_r     = '0;
        rnd       = lcg_next(SEED);
        wait_left = rnd[17:16];
    end

    // responses change on the falling edge only
    always @(negedge CLK) begin
        if (ack) begin
            ack = 1'b0;                 // one cycle ack
        end else if (cyc && stb) begin
            if (wait_left == 2'd0) begin
                ack       = 1'b1;
                dat_r     = mem[adr[7:2]];
                rnd       = lcg_next(rnd);
                wait_left = rnd[17:16];   // 0 to 3 wait states
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

endmodule

// ==== tb_decode_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_defines.svh"

module tb_decode_frontend;

    localparam int RESET_CYCLES = 16;
    localparam int SEQ_WORDS    = 40;
    localparam int REDIR_WORDS  = 20;
    localparam int FETCH_WORDS  = SEQ_WORDS + REDIR_WORDS + 4;  // plus words dropped on redirect
    localparam int CYCLE_LIMIT  = 64 * FETCH_WORDS + RESET_CYCLES;
    localparam int T_RESET = 0, T_SEQ = 1, T_IMM = 2, T_STALL = 3, T_REDIR = 4, T_ISSUE = 5;

    logic CLK, rst_n, stall;
    logic ibus_cyc, ibus_stb, ibus_ack;
    logic [31:0] ibus_adr, ibus_dat_r;
    logic cfg_cyc, cfg_stb, cfg_we, cfg_ack;
    logic [1:0] cfg_adr;
    logic [31:0] cfg_dat_w, cfg_dat_r;
    logic dec_valid, dec_illegal;
    logic [31:0] dec_pc, dec_imm;
    frontend_pkg::opcode_e dec_opcode;
    logic [4:0] dec_rd, dec_rs1, dec_rs2;
    logic [11:0] dec_csr;
    logic [2:0] dec_funct3;
    logic [6:0] dec_funct7;

    logic [31:0] seed, exp_pc, ref_word, rd_val;
    logic [31:0] new_pc;        // pc that fetch restarts from
    logic [6:0]  dec_op_bits;
    logic [109:0] out_now, out_prev;
    logic        stall_on;
    logic        restart_due;
    int          err [0:5];
    string       names [0:5];
    int          pc_test, tb_issued, cycles, exp_issued, total;
    int          restarts, restarts_seen;

    decode_frontend uut (.*);

    tb_imem_model #(.SEED(32'h94d1)) u_mem (
        .CLK(CLK), .cyc(ibus_cyc), .stb(ibus_stb), .adr(ibus_adr),
        .dat_r(ibus_dat_r), .ack(ibus_ack)
    );

    always #20 CLK = ~CLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // reference decode

    function automatic logic known_opcode(input logic [6:0] op);
        return op inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23,
                          7'h13, 7'h33, 7'h0f, 7'h73};
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        logic [31:0] sx;
        sx = 32'($signed(w) >>> 20);    // sign-extended 31:20
        case (w[6:0])
            7'h67, 7'h03, 7'h13, 7'h0f, 7'h73: return sx;
            7'h23: return {sx[31:5], w[11:7]};
            7'h63: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            7'h37, 7'h17: return {w[31:12], 12'h000};
            7'h6f: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    assign ref_word    = u_mem.mem[dec_pc[7:2]];
    assign dec_op_bits = dec_opcode;
    assign restart_due = (restarts != restarts_seen);
    assign out_now     = {dec_valid, dec_pc, dec_op_bits, dec_rd, dec_rs1, dec_rs2, dec_csr,
                          dec_funct3, dec_funct7, dec_imm, dec_illegal};

    // ~~~~~~~~~~~~~~~~~~~~
    // scoreboard state

    always @(posedge CLK) begin
        cycles   <= cycles + 1;
        out_prev <= out_now;
        if (!rst_n) begin
            exp_pc        <= `RESET_PC;
            tb_issued     <= 0;
            restarts_seen <= 0;
        end else begin
            if (restart_due) begin
                exp_pc        <= new_pc;
                restarts_seen <= restarts;
            end else if (dec_valid && !stall) begin
                exp_pc <= exp_pc + 32'd4;
            end
            if (dec_valid && !stall) begin
                tb_issued <= tb_issued + 1;
            end
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, decode stopped making progress", cycles);
            $display("Errors found");
            $finish;
        end
    end

    always @(negedge CLK) begin
        if (stall_on) begin
            seed  = lcg_next(seed);
            stall = (seed[15:14] == 2'b00);   // about one cycle in four
        end else begin
            stall = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks

    check_pc: assert property (@(posedge CLK) disable iff (!rst_n)
        dec_valid |-> dec_pc == exp_pc)
    else begin
        err[pc_test]++;
        $display("** Error %s: pc expected %h actual %h", names[pc_test],
                 $sampled(exp_pc), $sampled(dec_pc));
    end

    check_fields: assert property (@(posedge CLK) disable iff (!rst_n)
        dec_valid |-> {dec_op_bits, dec_rd, dec_funct3, dec_rs1, dec_rs2, dec_funct7}
                      == {ref_word[6:0], ref_word[11:7], ref_word[14:12], ref_word[19:15],
                          ref_word[24:20], ref_word[31:25]})
    else begin
        err[T_SEQ]++;
        $display("** Error %s: word expected %h actual fields %h", names[T_SEQ],
                 $sampled(ref_word), $sampled({dec_funct7, dec_rs2, dec_rs1, dec_funct3,
                 dec_rd, dec_op_bits}));
    end

    check_imm: assert property (@(posedge CLK) disable iff (!rst_n)
        dec_valid |-> dec_imm == ref_imm(ref_word))
    else begin
        err[T_IMM]++;
        $display("** Error %s: imm expected %h actual %h", names[T_IMM],
                 ref_imm($sampled(ref_word)), $sampled(dec_imm));
    end

    check_csr: assert property (@(posedge CLK) disable iff (!rst_n)
        (dec_valid && ref_word[6:0] == 7'h73) |-> dec_csr == ref_word[31:20])
    else begin
        err[T_IMM]++;
        $display("** Error %s: csr expected %h actual %h", names[T_IMM],
                 $sampled(ref_word[31:20]), $sampled(dec_csr));
    end

    check_illegal: assert property (@(posedge CLK) disable iff (!rst_n)
        dec_valid |-> dec_illegal == !known_opcode(ref_word[6:0]))
    else begin
        err[T_IMM]++;
        $display("** Error %s: illegal expected %b actual %b", names[T_IMM],
                 !known_opcode($sampled(ref_word[6:0])), $sampled(dec_illegal));
    end

    check_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        ($past(stall) && !$past(restart_due)) |-> out_now == out_prev)
    else begin
        err[T_STALL]++;
        $display("** Error %s: outputs expected %h actual %h", names[T_STALL],
                 $sampled(out_prev), $sampled(out_now));
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // config bus access

    task automatic cfg_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int issued_at_req);
        @(negedge CLK);
        cfg_cyc   = 1'b1;
        cfg_stb   = 1'b1;
        cfg_we    = we;
        cfg_adr   = adr;
        cfg_dat_w = wdata;
        issued_at_req = tb_issued;
        do @(negedge CLK); while (!cfg_ack);
        rdata   = cfg_dat_r;
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
        cfg_we  = 1'b0;
    endtask

    task automatic wait_issued(input int n);
        int target;
        target = tb_issued + n;
        while (tb_issued < target) @(negedge CLK);
    endtask

    task automatic report_test(input int t);
        $display("test %-18s %0d errors", names[t], err[t]);
    endtask

    initial begin
        names = '{"reset_state", "sequential_decode", "immediates", "stall_hold",
                  "redirect_flush", "issue_counter"};
        foreach (err[i]) err[i] = 0;
        CLK       = 1'b0;
        rst_n     = 1'b0;
        stall     = 1'b0;
        stall_on  = 1'b0;
        cfg_cyc   = 1'b0;
        cfg_stb   = 1'b0;
        cfg_we    = 1'b0;
        cfg_adr   = '0;
        cfg_dat_w = '0;
        cycles    = 0;
        pc_test   = T_SEQ;
        seed      = 32'h94d1;
        new_pc    = `RESET_PC;
        restarts  = 0;
        for (int i = 0; i < 64; i++) begin
            seed = lcg_next(seed);
            u_mem.mem[i] = seed ^ {24'h0, i[5:0], 2'b00};
        end
        u_mem.mem[0] = 32'h8001_0093;   // addi i-type
        u_mem.mem[1] = 32'hfe21_2e23;   // sw s-type
        u_mem.mem[2] = 32'hfe20_8ee3;   // beq b-type
        u_mem.mem[3] = 32'habcd_e0b7;   // lui u-type
        u_mem.mem[4] = 32'h8000_00ef;   // jal j-type
        u_mem.mem[5] = 32'h3412_9073;   // csrrw
        u_mem.mem[6] = 32'h0000_007f;   // unknown opcode
        u_mem.mem[7] = 32'h0000_0000;   // low bits not 11

        repeat (RESET_CYCLES) @(negedge CLK);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge CLK);
            assert (!dec_valid && !ibus_cyc && !ibus_stb && !cfg_ack) else begin
                err[T_RESET]++;
                $display("bus or decode activity seen before enable was written");
            end
        end
        for (int a = 0; a < 3; a++) begin
            cfg_access(1'b0, 2'(a), '0, rd_val, exp_issued);
            assert (rd_val == 32'h0) else begin
                err[T_RESET]++;
                $display("** Error %s: reg %0d expected %h actual %h", names[T_RESET],
                         a, 32'h0, rd_val);
            end
        end
        report_test(T_RESET);

        stall_on = 1'b1;
        cfg_access(1'b1, `CFG_START_PC, 32'h0, rd_val, exp_issued);
        new_pc = 32'h0;
        cfg_access(1'b1, `CFG_CTRL, 32'h1, rd_val, exp_issued);
        restarts++;                     // fetch starts at start pc
        wait_issued(SEQ_WORDS);
        report_test(T_SEQ);

        pc_test = T_REDIR;
        cfg_access(1'b1, `CFG_START_PC, 32'h40, rd_val, exp_issued);
        new_pc = 32'h40;
        cfg_access(1'b1, `CFG_CTRL, 32'h3, rd_val, exp_issued);
        restarts++;                     // redirect pulse
        wait_issued(REDIR_WORDS);
        report_test(T_REDIR);

        cfg_access(1'b0, `CFG_ISSUED, '0, rd_val, exp_issued);
        assert (rd_val == 32'(exp_issued)) else begin
            err[T_ISSUE]++;
            $display("** Error %s: expected %0d actual %0d", names[T_ISSUE],
                     exp_issued, rd_val);
        end
        report_test(T_ISSUE);
        report_test(T_IMM);
        report_test(T_STALL);

        total = 0;
        foreach (err[i]) total += err[i];
        $display("%0d tests, %0d errors, %0d instructions issued", 6, total, tb_issued);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
frontend_pkg.sv
fetch_unit.sv
decode_1st.sv
decode_2nd.sv
frontend_cfg.sv
decode_frontend.sv
tb_imem_model.sv
tb_decode_frontend.sv
+incdir+.

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_decode_frontend \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    exit 1
fi
exit 0
